/* logic/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    localparam int TAG_W = 20;
    localparam int INDEX_W = 8;
    localparam int OFFSET_W = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_WAYS = 2;
    localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_s;

    // bus word or tag/index/offset fields
    typedef union packed {
        logic [31:0] raw;
        cache_addr_s f;
    } cache_addr_u;

    typedef logic [32*WORDS_PER_LINE-1:0] line_t;

    // one way as returned by the arrays
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
        logic             dirty;
        line_t            line;
    } way_rd_s;

    // lookup to refill hand-off
    typedef struct packed {
        cache_addr_u      addr;
        logic             op;
        logic [3:0]       wstrb;
        logic [31:0]      wdata;
        logic             victim_way;
        logic             victim_dirty;
        logic [TAG_W-1:0] victim_tag;
        line_t            victim_line;
    } miss_job_s;

    // valid is set together with tag_we
    typedef struct packed {
        logic                  data_we;
        logic                  way;
        logic [INDEX_W-1:0]    index;
        logic [WORD_SEL_W-1:0] word;
        logic [3:0]            strb;
        logic [31:0]           data;
        logic                  tag_we;
        logic [TAG_W-1:0]      tag;
        logic                  dirty;
    } array_wr_s;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } fill_resp_s;

endpackage

`default_nettype wire

/* logic/cache_arrays.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_arrays (
    input  wire                                            clk,
    input  wire                                            rst,
    input  wire [cache_pkg::INDEX_W-1:0]                   rd_index,
    output cache_pkg::way_rd_s [cache_pkg::NUM_WAYS-1:0]   rd_ways,
    input  wire cache_pkg::array_wr_s                      hit_wr,
    input  wire cache_pkg::array_wr_s                      fill_wr
);

    localparam int SETS = 1 << cache_pkg::INDEX_W;

    logic [cache_pkg::TAG_W-1:0]              tag_mem [cache_pkg::NUM_WAYS][SETS];
    logic [cache_pkg::NUM_WAYS-1:0][SETS-1:0] valid_mem;
    logic [cache_pkg::NUM_WAYS-1:0][SETS-1:0] dirty_mem;
    cache_pkg::line_t                         data_mem [cache_pkg::NUM_WAYS][SETS];

    cache_pkg::array_wr_s wr;

    // shared write port, lookup and refill are never active together
    always_comb begin
        if (hit_wr.data_we || hit_wr.tag_we) begin
            wr = hit_wr;
        end else begin
            wr = fill_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem <= '0;
        end else if (wr.tag_we) begin
            valid_mem[wr.way][wr.index] <= 1'b1;
        end
    end

    // tag and dirty only change with tag_we
    always_ff @(posedge clk) begin
        if (wr.tag_we) begin
            tag_mem[wr.way][wr.index] <= wr.tag;
            dirty_mem[wr.way][wr.index] <= wr.dirty;
        end
    end

    // byte-strobed word write into one line
    always_ff @(posedge clk) begin
        if (wr.data_we) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.strb[b]) begin
                    data_mem[wr.way][wr.index][wr.word*32 + b*8 +: 8] <= wr.data[b*8 +: 8];
                end
            end
        end
    end

    // registered read of both ways, old data on a same-edge write
    always_ff @(posedge clk) begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            rd_ways[w].tag <= tag_mem[w][rd_index];
            rd_ways[w].valid <= valid_mem[w][rd_index];
            rd_ways[w].dirty <= dirty_mem[w][rd_index];
            rd_ways[w].line <= data_mem[w][rd_index];
        end
    end

endmodule

`default_nettype wire

/* logic/cache_lookup.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_lookup #(
    parameter logic [7:0] LFSR_SEED = 8'h5a
) (
    input  wire                                            clk,
    input  wire                                            rst,
    input  wire                                            valid,
    input  wire                                            op,
    input  wire cache_pkg::cache_addr_u                    addr,
    input  wire [3:0]                                      wstrb,
    input  wire [31:0]                                     wdata,
    output logic                                           addr_ok,
    output logic                                           data_ok,
    output logic [31:0]                                    rdata,
    output logic [cache_pkg::INDEX_W-1:0]                  rd_index,
    input  wire cache_pkg::way_rd_s [cache_pkg::NUM_WAYS-1:0] rd_ways,
    output cache_pkg::array_wr_s                           hit_wr,
    output logic                                           miss_start,
    output cache_pkg::miss_job_s                           miss_job,
    input  wire cache_pkg::fill_resp_s                     fill_resp,
    input  wire                                            fill_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_WAIT_MISS
    } state_e;

    typedef struct packed {
        cache_pkg::cache_addr_u addr;
        logic                   op;
        logic [3:0]             wstrb;
        logic [31:0]            wdata;
    } cpu_req_s;

    state_e                             state;
    state_e                             state_next;
    cpu_req_s                           req;
    logic [7:0]                         lfsr;
    logic                               accept;
    logic [cache_pkg::NUM_WAYS-1:0]     hit_vec;
    logic                               hit;
    logic                               hit_way;
    logic                               victim;
    logic                               write_hit;
    logic [cache_pkg::WORD_SEL_W-1:0]   word_sel;
    logic [31:0]                        hit_word;

    assign addr_ok = (state == S_IDLE);
    assign accept = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (accept) begin
                    state_next = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                state_next = hit ? S_IDLE : S_WAIT_MISS;
            end
            S_WAIT_MISS: begin
                if (fill_done) begin
                    state_next = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req <= '{addr: addr, op: op, wstrb: wstrb, wdata: wdata};
        end
    end

    // x^8 + x^6 + x^5 + x^4 + 1, free running
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    // index goes to the arrays on the accept edge, ways come back in lookup
    assign rd_index = (state == S_IDLE) ? addr.f.index : req.addr.f.index;

    always_comb begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            hit_vec[w] = rd_ways[w].valid && (rd_ways[w].tag == req.addr.f.tag);
        end
    end

    assign hit = |hit_vec;
    assign hit_way = hit_vec[1];
    assign victim = lfsr[0];
    assign word_sel = req.addr.f.offset[cache_pkg::OFFSET_W-1:2];
    assign hit_word = rd_ways[hit_way].line[word_sel*32 +: 32];
    assign write_hit = (state == S_LOOKUP) && hit && req.op;

    // store hit rewrites the tag too so that dirty gets set
    always_comb begin
        hit_wr.data_we = write_hit;
        hit_wr.way = hit_way;
        hit_wr.index = req.addr.f.index;
        hit_wr.word = word_sel;
        hit_wr.strb = req.wstrb;
        hit_wr.data = req.wdata;
        hit_wr.tag_we = write_hit;
        hit_wr.tag = req.addr.f.tag;
        hit_wr.dirty = 1'b1;
    end

    assign miss_start = (state == S_LOOKUP) && !hit;

    always_comb begin
        miss_job.addr = req.addr;
        miss_job.op = req.op;
        miss_job.wstrb = req.wstrb;
        miss_job.wdata = req.wdata;
        miss_job.victim_way = victim;
        miss_job.victim_dirty = rd_ways[victim].valid && rd_ways[victim].dirty;
        miss_job.victim_tag = rd_ways[victim].tag;
        miss_job.victim_line = rd_ways[victim].line;
    end

    // hit answers in lookup, a miss answers on the matching refill beat
    assign data_ok = ((state == S_LOOKUP) && hit) ||
                     ((state == S_WAIT_MISS) && fill_resp.valid);
    assign rdata = (state == S_WAIT_MISS) ? fill_resp.data : hit_word;

endmodule

`default_nettype wire

/* logic/cache_refill.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_refill (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          miss_start,
    input  wire cache_pkg::miss_job_s    miss_job,
    output cache_pkg::array_wr_s         fill_wr,
    output cache_pkg::fill_resp_s        fill_resp,
    output logic                         fill_done,
    output logic                         rd_req,
    output logic [31:0]                  rd_addr,
    input  wire                          rd_rdy,
    input  wire                          ret_valid,
    input  wire                          ret_last,
    input  wire [31:0]                   ret_data,
    output logic                         wr_req,
    output logic [31:0]                  wr_addr,
    output cache_pkg::line_t             wr_data,
    input  wire                          wr_rdy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITEBACK,
        S_REQUEST,
        S_REFILL
    } state_e;

    state_e                             state;
    state_e                             state_next;
    cache_pkg::miss_job_s               job;
    logic [cache_pkg::WORD_SEL_W-1:0]   beat_cnt;
    cache_pkg::cache_addr_u             wb_addr;
    cache_pkg::cache_addr_u             line_addr;
    logic                               beat;
    logic                               beat_hit;
    logic [31:0]                        strb_mask;
    logic [31:0]                        fill_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (miss_start) begin
                    // clean victim goes straight to the line read
                    state_next = miss_job.victim_dirty ? S_WRITEBACK : S_REQUEST;
                end
            end
            S_WRITEBACK: begin
                if (wr_rdy) begin
                    state_next = S_REQUEST;
                end
            end
            S_REQUEST: begin
                if (rd_rdy) begin
                    state_next = S_REFILL;
                end
            end
            S_REFILL: begin
                if (beat && ret_last) begin
                    state_next = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && miss_start) begin
            job <= miss_job;
        end
    end

    assign beat = (state == S_REFILL) && ret_valid;

    // holds through gaps between beats
    always_ff @(posedge clk) begin
        if (rst || (state == S_REQUEST)) begin
            beat_cnt <= '0;
        end else if (beat) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_comb begin
        wb_addr.f.tag = job.victim_tag;
        wb_addr.f.index = job.addr.f.index;
        wb_addr.f.offset = '0;
        line_addr = job.addr;
        line_addr.f.offset = '0;
    end

    assign wr_req = (state == S_WRITEBACK);
    assign wr_addr = wb_addr.raw;
    assign wr_data = job.victim_line;
    assign rd_req = (state == S_REQUEST);
    assign rd_addr = line_addr.raw;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            strb_mask[b*8 +: 8] = {8{job.wstrb[b]}};
        end
    end

    // store bytes land on the beat of the requested word
    assign beat_hit = beat && (beat_cnt == job.addr.f.offset[cache_pkg::OFFSET_W-1:2]);
    assign fill_word = (beat_hit && job.op) ? ((ret_data & ~strb_mask) | (job.wdata & strb_mask))
                                            : ret_data;

    always_comb begin
        fill_wr.data_we = beat;
        fill_wr.way = job.victim_way;
        fill_wr.index = job.addr.f.index;
        fill_wr.word = beat_cnt;
        fill_wr.strb = 4'hf;
        fill_wr.data = fill_word;
        fill_wr.tag_we = beat && ret_last;
        fill_wr.tag = job.addr.f.tag;
        fill_wr.dirty = job.op;
    end

    assign fill_resp.valid = beat_hit;
    assign fill_resp.data = fill_word;
    assign fill_done = beat && ret_last;

endmodule

`default_nettype wire

/* logic/cache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_top #(
    parameter logic [7:0] LFSR_SEED = 8'h5a
) (
    input  wire          clk,
    input  wire          rst,
    // cpu side
    input  wire          valid,
    input  wire          op,
    input  wire [31:0]   addr,
    input  wire [3:0]    wstrb,
    input  wire [31:0]   wdata,
    output logic         addr_ok,
    output logic         data_ok,
    output logic [31:0]  rdata,
    // memory read channel
    output logic         rd_req,
    output logic [31:0]  rd_addr,
    input  wire          rd_rdy,
    input  wire          ret_valid,
    input  wire          ret_last,
    input  wire [31:0]   ret_data,
    // memory write channel, one line per transfer
    output logic         wr_req,
    output logic [31:0]  wr_addr,
    output logic [127:0] wr_data,
    input  wire          wr_rdy
);

    logic [cache_pkg::INDEX_W-1:0]                  rd_index;
    cache_pkg::way_rd_s [cache_pkg::NUM_WAYS-1:0]   rd_ways;
    cache_pkg::array_wr_s                           hit_wr;
    cache_pkg::array_wr_s                           fill_wr;
    logic                                           miss_start;
    cache_pkg::miss_job_s                           miss_job;
    cache_pkg::fill_resp_s                          fill_resp;
    logic                                           fill_done;

    cache_lookup #(
        .LFSR_SEED (LFSR_SEED)
    ) u_lookup (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .op         (op),
        .addr       (addr),
        .wstrb      (wstrb),
        .wdata      (wdata),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_index   (rd_index),
        .rd_ways    (rd_ways),
        .hit_wr     (hit_wr),
        .miss_start (miss_start),
        .miss_job   (miss_job),
        .fill_resp  (fill_resp),
        .fill_done  (fill_done)
    );

    cache_arrays u_arrays (
        .clk      (clk),
        .rst      (rst),
        .rd_index (rd_index),
        .rd_ways  (rd_ways),
        .hit_wr   (hit_wr),
        .fill_wr  (fill_wr)
    );

    cache_refill u_refill (
        .clk        (clk),
        .rst        (rst),
        .miss_start (miss_start),
        .miss_job   (miss_job),
        .fill_wr    (fill_wr),
        .fill_resp  (fill_resp),
        .fill_done  (fill_done),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_rdy     (wr_rdy)
    );

endmodule

`default_nettype wire

/* dv/mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_model #(
    parameter logic [31:0] FILL_XOR = 32'h0
) (
    input  wire          clk,
    input  wire          rst,
    input  wire          rd_req,
    input  wire  [31:0]  rd_addr,
    output logic         rd_rdy,
    output logic         ret_valid,
    output logic         ret_last,
    output logic [31:0]  ret_data,
    input  wire          wr_req,
    input  wire  [31:0]  wr_addr,
    input  wire  [127:0] wr_data,
    output logic         wr_rdy
);

    // sparse storage, untouched words read as the fill pattern
    logic [31:0] mem [logic [31:0]];
    logic [31:0] line_base;
    int          beats_left;
    integer      seed = 37;
    logic        rd_rdy_q = 1'b0;
    logic        wr_rdy_q = 1'b0;
    logic        ret_valid_q = 1'b0;
    logic        ret_last_q = 1'b0;
    logic [31:0] ret_data_q = '0;

    assign rd_rdy = rd_rdy_q;
    assign wr_rdy = wr_rdy_q;
    assign ret_valid = ret_valid_q;
    assign ret_last = ret_last_q;
    assign ret_data = ret_data_q;

    function automatic logic [31:0] word_at(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a[31:2], 2'b00} ^ FILL_XOR;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            rd_rdy_q <= 1'b0;
            wr_rdy_q <= 1'b0;
            ret_valid_q <= 1'b0;
            ret_last_q <= 1'b0;
            beats_left <= 0;
        end else begin
            // whole line lands on the handshake edge
            if (wr_req && wr_rdy_q) begin
                for (int w = 0; w < 4; w++) begin
                    mem[{wr_addr[31:4], 4'h0} + 32'(w * 4)] = wr_data[w*32 +: 32];
                end
                wr_rdy_q <= 1'b0;
            end else if (wr_req) begin
                wr_rdy_q <= ($random(seed) & 3) == 0;
            end
            ret_valid_q <= 1'b0;
            ret_last_q <= 1'b0;
            if (rd_req && rd_rdy_q) begin
                line_base <= {rd_addr[31:4], 4'h0};
                beats_left <= 4;
                rd_rdy_q <= 1'b0;
            end else if (rd_req && beats_left == 0) begin
                rd_rdy_q <= ($random(seed) & 3) == 0;
            end else if (beats_left > 0 && ($random(seed) & 1) == 0) begin
                // beats in order, random gaps between them
                ret_valid_q <= 1'b1;
                ret_last_q <= (beats_left == 1);
                ret_data_q <= word_at(line_base + 32'((4 - beats_left) * 4));
                beats_left <= beats_left - 1;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/cache_props.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_props (
    input wire        clk,
    input wire        rst,
    input wire        addr_ok,
    input wire        data_ok,
    input wire        rd_req,
    input wire        rd_rdy,
    input wire [31:0] rd_addr,
    input wire        wr_req,
    input wire        wr_rdy,
    input wire [31:0] wr_addr
);

    int failures = 0;

    // one memory channel at a time
    req_exclusive: assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req))
        else begin
            failures++;
            $error("rd_req and wr_req are high together");
        end

    // request level and address hold until the ready cycle
    rd_req_hold: assert property (@(posedge clk) disable iff (rst)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else begin
            failures++;
            $error("rd_req dropped or rd_addr changed before rd_rdy");
        end

    wr_req_hold: assert property (@(posedge clk) disable iff (rst)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr))
        else begin
            failures++;
            $error("wr_req dropped or wr_addr changed before wr_rdy");
        end

    data_ok_busy: assert property (@(posedge clk) disable iff (rst) data_ok |-> !addr_ok)
        else begin
            failures++;
            $error("data_ok is high while addr_ok is high");
        end

endmodule

bind cache_top cache_props u_props (
    .clk     (clk),
    .rst     (rst),
    .addr_ok (addr_ok),
    .data_ok (data_ok),
    .rd_req  (rd_req),
    .rd_rdy  (rd_rdy),
    .rd_addr (rd_addr),
    .wr_req  (wr_req),
    .wr_rdy  (wr_rdy),
    .wr_addr (wr_addr)
);

`default_nettype wire

/* dv/cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_tb;

    localparam logic [31:0] FILL_XOR = 32'h5ca1_ab1e;
    localparam int          TIMEOUT = 500;

    logic         clk;
    logic         rst;
    logic         valid;
    logic         op;
    logic [31:0]  addr;
    logic [3:0]   wstrb;
    logic [31:0]  wdata;
    logic         addr_ok;
    logic         data_ok;
    logic [31:0]  rdata;
    logic         rd_req;
    logic [31:0]  rd_addr;
    logic         rd_rdy;
    logic         ret_valid;
    logic         ret_last;
    logic [31:0]  ret_data;
    logic         wr_req;
    logic [31:0]  wr_addr;
    logic [127:0] wr_data;
    logic         wr_rdy;

    // cpu writes over the fill pattern by word address
    logic [31:0]  shadow [logic [31:0]];
    int           errors;
    int           timeouts;
    int           rd_count;
    int           wb_count;
    logic [31:0]  last_rd_addr;
    logic [31:0]  last_wr_addr;
    int           latency;
    logic [31:0]  got;
    integer       seed;

    cache_top #(
        .LFSR_SEED (8'h5a)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .op        (op),
        .addr      (addr),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    mem_model #(
        .FILL_XOR (FILL_XOR)
    ) u_mem (
        .clk       (clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        logic [31:0] wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return wa ^ FILL_XOR;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp == act) else begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic abort_run(input string what);
        timeouts++;
        $display("timeout while %s", what);
        $display("errors %0d, property failures %0d, timeouts %0d",
                 errors, u_dut.u_props.failures, timeouts);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // memory handshakes seen while a request is outstanding
    task automatic note_bus();
        if (rd_req && rd_rdy) begin
            rd_count++;
            last_rd_addr = rd_addr;
        end
        if (wr_req && wr_rdy) begin
            wb_count++;
            last_wr_addr = wr_addr;
        end
    endtask

    // one request leaves rdata in got and acceptance-to-data_ok cycles in latency
    task automatic access(input logic wr, input logic [31:0] a, input logic [3:0] strb,
                          input logic [31:0] data);
        int n;
        n = 0;
        while (!addr_ok) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("waiting for addr_ok");
            end
        end
        @(posedge clk);
        valid <= 1'b1;
        op <= wr;
        addr <= a;
        wstrb <= strb;
        wdata <= data;
        @(posedge clk);
        valid <= 1'b0;
        @(negedge clk);
        latency = 1;
        note_bus();
        while (!data_ok) begin
            @(negedge clk);
            latency++;
            note_bus();
            if (latency > TIMEOUT) begin
                abort_run("waiting for data_ok");
            end
        end
        got = rdata;
    endtask

    task automatic write_word(input logic [31:0] a, input logic [3:0] strb,
                              input logic [31:0] data);
        logic [31:0] w;
        access(1'b1, a, strb, data);
        w = expected_word(a);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        shadow[{a[31:2], 2'b00}] = w;
    endtask

    task automatic read_check(input string name, input logic [31:0] a);
        logic [31:0] exp;
        exp = expected_word(a);
        access(1'b0, a, 4'h0, 32'h0);
        check_value(name, exp, got);
    endtask

    initial begin
        int          rd_before;
        logic [31:0] r;
        logic [31:0] a;
        seed = 37;
        errors = 0;
        timeouts = 0;
        rd_count = 0;
        wb_count = 0;
        last_rd_addr = '0;
        last_wr_addr = '0;
        rst = 1'b1;
        valid = 1'b0;
        op = 1'b0;
        addr = '0;
        wstrb = '0;
        wdata = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // idle outputs before the first request
        repeat (3) begin
            @(negedge clk);
            check_value("reset addr_ok", 32'd1, {31'd0, addr_ok});
            check_value("reset data_ok", 32'd0, {31'd0, data_ok});
            check_value("reset rd_req", 32'd0, {31'd0, rd_req});
            check_value("reset wr_req", 32'd0, {31'd0, wr_req});
        end

        a = 32'h0001_2344;
        rd_before = rd_count;
        read_check("read miss data", a);
        check_value("read miss fetch", rd_before + 1, rd_count);
        check_value("read miss rd_addr", 32'h0001_2340, last_rd_addr);
        rd_before = rd_count;
        read_check("read hit data", a);
        check_value("read hit latency", 32'd1, latency);
        check_value("read hit rd_req", rd_before, rd_count);

        write_word(a, 4'b0101, 32'hdead_beef);
        check_value("write hit latency", 32'd1, latency);
        read_check("write hit merge", a);

        // word 2 of a fresh line
        a = 32'h0004_5678;
        rd_before = rd_count;
        write_word(a, 4'b1100, 32'h1234_5678);
        check_value("write miss fetch", rd_before + 1, rd_count);
        read_check("write miss merge", a);
        read_check("write miss word 0", 32'h0004_5670);
        read_check("write miss word 1", 32'h0004_5674);
        read_check("write miss word 3", 32'h0004_567c);

        // three dirty tags in a two-way set
        wb_count = 0;
        for (int t = 1; t <= 3; t++) begin
            write_word({12'h001, 8'(t), 8'h9a, 4'h4}, 4'hf, 32'hc0de_0000 | 32'(t));
        end
        check_value("evict write-back", 32'd1, {31'd0, wb_count > 0});
        check_value("evict wr_addr index", 32'h9a, {24'd0, last_wr_addr[11:4]});
        check_value("evict wr_addr offset", 32'd0, {28'd0, last_wr_addr[3:0]});
        for (int t = 1; t <= 3; t++) begin
            read_check("evict read back", {12'h001, 8'(t), 8'h9a, 4'h4});
        end

        // eight tags over four sets
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            a = {12'h0a0, 5'd0, r[2:0], 6'd0, r[4:3], r[6:5], 2'b00};
            if (r[7]) begin
                write_word(a, r[11:8], $random(seed));
            end else begin
                read_check("random read", a);
            end
        end

        $display("errors %0d, property failures %0d, timeouts %0d",
                 errors, u_dut.u_props.failures, timeouts);
        if (errors == 0 && u_dut.u_props.failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
logic/cache_pkg.sv
logic/cache_arrays.sv
logic/cache_lookup.sv
logic/cache_refill.sv
logic/cache_top.sv
dv/mem_model.sv
dv/cache_props.sv
dv/cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := cache_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "run ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
